// ==== logic/i2c_pkg.sv ====
// I2C master shared definitions
// Local-bus widths, register map, control and status bit positions,
// and the packed structs that carry signals between the blocks
package i2c_pkg;

    // Widths
    localparam int LB_ADR_W  = 4;
    localparam int LB_DAT_W  = 32;
    localparam int BYTE_W    = 8;
    localparam int BIT_CNT_W = 4;

    // Register map
    localparam logic [LB_ADR_W-1:0] ADR_CTL    = LB_ADR_W'(0);
    localparam logic [LB_ADR_W-1:0] ADR_STA    = LB_ADR_W'(1);
    localparam logic [LB_ADR_W-1:0] ADR_BEAT   = LB_ADR_W'(2);
    localparam logic [LB_ADR_W-1:0] ADR_WR_DAT = LB_ADR_W'(3);
    localparam logic [LB_ADR_W-1:0] ADR_RD_DAT = LB_ADR_W'(4);

    // Control register bits
    localparam int CTL_RUN = 0;
    localparam int CTL_STR = 1;
    localparam int CTL_STP = 2;
    localparam int CTL_WR  = 3;
    localparam int CTL_RD  = 4;
    localparam int CTL_ACK = 5;
    localparam int CTL_W   = 6;

    // Status register bits
    localparam int STA_BUSY = 0;
    localparam int STA_RDY  = 1;
    localparam int STA_ACK  = 2;
    localparam int STA_BUS  = 3;
    localparam int STA_W    = 4;

    typedef struct packed {
        logic [LB_ADR_W-1:0] adr;
        logic                wr;
        logic                rd;
        logic [LB_DAT_W-1:0] din;
    } lb_req_t;

    typedef struct packed {
        logic [LB_DAT_W-1:0] dout;
        logic                vld;
    } lb_rsp_t;

    // Decoded control bits plus the bus-owned flag
    typedef struct packed {
        logic run;
        logic str;
        logic stp;
        logic wr;
        logic rd;
        logic ack;
        logic bus;
    } i2c_cmd_t;

    typedef struct packed {
        logic busy_set;
        logic rdy_set;
        logic ack_set;
    } i2c_evt_t;

    // Strobes from the sequencer to the shift path
    typedef struct packed {
        logic scl_set;
        logic scl_clr;
        logic sda_set;
        logic sda_clr;
        logic shft_ld;
        logic shft_nxt;
        logic bit_ld;
        logic bit_dec;
    } line_ctl_t;

    typedef struct packed {
        logic scl_in;
        logic sda_in;
        logic shft_msb;
        logic bit_end;
    } path_sta_t;

endpackage

// ==== logic/i2c_beat_timer.sv ====
// I2C beat timer
// Reloading down-counter; emits a one-cycle beat every beat_len+1 cycles
// while run is high
`timescale 1ns/10ps

module i2c_beat_timer
#(
    parameter int BEAT_W = 16
)
(
    input  logic              CLK_IN,
    input  logic              RST_IN,
    input  logic              run,
    input  logic [BEAT_W-1:0] beat_len,
    output logic              beat
);

    logic [BEAT_W-1:0] cnt;
    logic              cnt_zero;
    logic              zero_q;

    assign cnt_zero = (cnt == '0);

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN || !run)
            cnt <= '0;
        else if (cnt_zero)
            cnt <= beat_len;
        else
            cnt <= cnt - 1'b1;
    end

    // Held high while stopped so no beat slips out on the way down
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN || !run)
            zero_q <= 1'b1;
        else
            zero_q <= cnt_zero;
    end

    // Rising edge of the zero flag
    assign beat = cnt_zero && !zero_q;

    a_beat_single : assert property (@(posedge CLK_IN) disable iff (RST_IN)
        beat |=> !beat)
        else $error("beat high on two cycles");

endmodule

// ==== logic/i2c_lb_regs.sv ====
// I2C master register file
// Registers the local-bus request, decodes it and returns read data one
// cycle after the read strobe. Holds control, status, beat and data registers
`timescale 1ns/10ps

module i2c_lb_regs
#(
    parameter int BEAT_W = 16
)
(
    input  logic                       CLK_IN,
    input  logic                       RST_IN,
    input  i2c_pkg::lb_req_t           lb_req,
    input  i2c_pkg::i2c_evt_t          evt,
    input  logic [i2c_pkg::BYTE_W-1:0] rd_byte,
    output i2c_pkg::lb_rsp_t           lb_rsp,
    output i2c_pkg::i2c_cmd_t          cmd,
    output logic [BEAT_W-1:0]          beat,
    output logic [i2c_pkg::BYTE_W-1:0] wr_byte
);
    import i2c_pkg::*;

    lb_req_t          req_q;
    logic [CTL_W-1:0] ctl_r;
    logic [STA_W-1:0] sta;
    logic             busy;
    logic             rdy;
    logic             ack;
    logic             bus;
    logic             run;
    logic             cmd_any;
    logic             wr_ctl;
    logic             wr_sta;
    logic             wr_beat;
    logic             wr_wdat;

    // Request register
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            req_q <= '0;
        else
            req_q <= lb_req;
    end

    assign wr_ctl  = req_q.wr && (req_q.adr == ADR_CTL);
    assign wr_sta  = req_q.wr && (req_q.adr == ADR_STA);
    assign wr_beat = req_q.wr && (req_q.adr == ADR_BEAT);
    assign wr_wdat = req_q.wr && (req_q.adr == ADR_WR_DAT);

    assign sta[STA_BUSY] = busy;
    assign sta[STA_RDY]  = rdy;
    assign sta[STA_ACK]  = ack;
    assign sta[STA_BUS]  = bus;

    // Read data mux, valid in the cycle after rd
    always_comb
    begin
        lb_rsp.dout = '0;
        lb_rsp.vld  = req_q.rd;
        case (req_q.adr)
            ADR_CTL    : lb_rsp.dout[CTL_W-1:0]  = ctl_r;
            ADR_STA    : lb_rsp.dout[STA_W-1:0]  = sta;
            ADR_BEAT   : lb_rsp.dout[BEAT_W-1:0] = beat;
            ADR_WR_DAT : lb_rsp.dout[BYTE_W-1:0] = wr_byte;
            ADR_RD_DAT : lb_rsp.dout[BYTE_W-1:0] = rd_byte;
            default    : lb_rsp.dout = '0;
        endcase
    end

    // Control register, command bits drop once the sequencer takes them
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            ctl_r <= '0;
        else if (wr_ctl)
            ctl_r <= req_q.din[CTL_W-1:0];
        else if (evt.busy_set)
        begin
            ctl_r[CTL_STR] <= 1'b0;
            ctl_r[CTL_STP] <= 1'b0;
            ctl_r[CTL_WR]  <= 1'b0;
            ctl_r[CTL_RD]  <= 1'b0;
        end
    end

    assign run     = ctl_r[CTL_RUN];
    assign cmd_any = ctl_r[CTL_STR] || ctl_r[CTL_STP] || ctl_r[CTL_WR] || ctl_r[CTL_RD];

    // Status flags
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN || !run)
        begin
            busy <= 1'b0;
            rdy  <= 1'b0;
            ack  <= 1'b0;
            bus  <= 1'b0;
        end
        else
        begin
            if (evt.rdy_set)
                busy <= 1'b0;
            else if (evt.busy_set)
                busy <= 1'b1;

            // Host clears ready by writing a one to it
            if (wr_sta && req_q.din[STA_RDY])
                rdy <= 1'b0;
            else if (evt.rdy_set)
                rdy <= 1'b1;

            if (cmd_any)
                ack <= 1'b0;
            else if (evt.ack_set)
                ack <= 1'b1;

            // Same priority as the sequencer, start wins over stop
            if (evt.busy_set && ctl_r[CTL_STR])
                bus <= 1'b1;
            else if (evt.busy_set && ctl_r[CTL_STP])
                bus <= 1'b0;
        end
    end

    // Beat and write data
    always_ff @(posedge CLK_IN)
    begin
        if (wr_beat)
            beat <= req_q.din[BEAT_W-1:0];
        if (wr_wdat)
            wr_byte <= req_q.din[BYTE_W-1:0];
    end

    assign cmd.run = run;
    assign cmd.str = ctl_r[CTL_STR];
    assign cmd.stp = ctl_r[CTL_STP];
    assign cmd.wr  = ctl_r[CTL_WR];
    assign cmd.rd  = ctl_r[CTL_RD];
    assign cmd.ack = ctl_r[CTL_ACK];
    assign cmd.bus = bus;

    // Sequencer only takes a command when the previous one has finished
    a_busy_set_idle : assert property (@(posedge CLK_IN) disable iff (RST_IN)
        evt.busy_set |-> !busy)
        else $error("busy_set while busy");

    a_vld_after_rd : assert property (@(posedge CLK_IN) disable iff (RST_IN)
        lb_req.rd |=> lb_rsp.vld)
        else $error("read not answered in the next cycle");

endmodule

// ==== logic/i2c_bit_fsm.sv ====
// I2C bus sequencer
// Beat-stepped FSM for start with bus-free check and recovery pulses,
// repeated start, stop, byte write with ACK sampling and byte read
`timescale 1ns/10ps

module i2c_bit_fsm
(
    input  logic                CLK_IN,
    input  logic                RST_IN,
    input  i2c_pkg::i2c_cmd_t   cmd,
    input  logic                beat,
    input  i2c_pkg::path_sta_t  fb,
    output i2c_pkg::line_ctl_t  ctl,
    output i2c_pkg::i2c_evt_t   evt
);
    import i2c_pkg::*;

    typedef enum logic [4:0] {
        st_idle,
        st_s_chk, st_s_pls, st_s_lo,
        st_rs_sda, st_rs_scl,
        st_b_lo, st_b_hi, st_b_hold, st_b_fall,
        st_a_hi, st_a_hold, st_a_fall, st_a_end,
        st_p_sda, st_p_scl, st_p_end
    } state_t;

    state_t cur;
    state_t nxt;
    logic   rd_op;

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN || !cmd.run)
        begin
            cur   <= st_idle;
            rd_op <= 1'b0;
        end
        else
        begin
            cur <= nxt;
            // Byte direction for the shared bit states
            if (evt.busy_set)
                rd_op <= !cmd.wr;
        end
    end

    always_comb
    begin
        nxt = cur;
        ctl = '0;
        evt = '0;
        if (beat)
        begin
            case (cur)
                st_idle :
                begin
                    evt.busy_set = cmd.str || cmd.stp || cmd.wr || cmd.rd;
                    if (cmd.str)
                        nxt = cmd.bus ? st_rs_sda : st_s_chk;
                    else if (cmd.stp)
                        nxt = st_p_sda;
                    else if (cmd.wr || cmd.rd)
                    begin
                        ctl.shft_ld = cmd.wr;
                        ctl.bit_ld  = 1'b1;
                        nxt         = st_b_lo;
                    end
                end
                // Both lines must read high before SDA may fall
                st_s_chk :
                begin
                    if (fb.scl_in && fb.sda_in)
                    begin
                        ctl.sda_clr = 1'b1;
                        nxt         = st_s_lo;
                    end
                    else
                    begin
                        ctl.scl_clr = 1'b1;
                        nxt         = st_s_pls;
                    end
                end
                st_s_pls :
                begin
                    ctl.scl_set = 1'b1;
                    nxt         = st_s_chk;
                end
                st_s_lo :
                begin
                    ctl.scl_clr = 1'b1;
                    evt.rdy_set = 1'b1;
                    nxt         = st_idle;
                end
                // Release SDA with SCL low, then SCL, then a normal start
                st_rs_sda :
                begin
                    ctl.sda_set = 1'b1;
                    nxt         = st_rs_scl;
                end
                st_rs_scl :
                begin
                    ctl.scl_set = 1'b1;
                    nxt         = st_s_chk;
                end
                // SCL is low here; put the next bit or the ACK slot on SDA
                st_b_lo :
                begin
                    if (fb.bit_end)
                    begin
                        ctl.sda_set = !rd_op || !cmd.ack;
                        ctl.sda_clr = rd_op && cmd.ack;
                        nxt         = st_a_hi;
                    end
                    else
                    begin
                        ctl.sda_set  = rd_op || fb.shft_msb;
                        ctl.sda_clr  = !rd_op && !fb.shft_msb;
                        ctl.shft_nxt = !rd_op;
                        ctl.bit_dec  = !rd_op;
                        nxt          = st_b_hi;
                    end
                end
                st_b_hi :
                begin
                    ctl.scl_set = 1'b1;
                    nxt         = st_b_hold;
                end
                st_b_hold : nxt = st_b_fall;
                // Read data is taken just before SCL falls
                st_b_fall :
                begin
                    ctl.scl_clr  = 1'b1;
                    ctl.shft_nxt = rd_op;
                    ctl.bit_dec  = rd_op;
                    nxt          = st_b_lo;
                end
                st_a_hi :
                begin
                    ctl.scl_set = 1'b1;
                    nxt         = st_a_hold;
                end
                st_a_hold : nxt = st_a_fall;
                st_a_fall :
                begin
                    ctl.scl_clr = 1'b1;
                    evt.ack_set = !rd_op && !fb.sda_in;
                    nxt         = st_a_end;
                end
                // After a write SDA is held low, ready for a stop
                st_a_end :
                begin
                    ctl.sda_clr = !rd_op;
                    evt.rdy_set = 1'b1;
                    nxt         = st_idle;
                end
                st_p_sda :
                begin
                    ctl.sda_clr = 1'b1;
                    nxt         = st_p_scl;
                end
                st_p_scl :
                begin
                    ctl.scl_set = 1'b1;
                    nxt         = st_p_end;
                end
                st_p_end :
                begin
                    ctl.sda_set = 1'b1;
                    evt.rdy_set = 1'b1;
                    nxt         = st_idle;
                end
                default : nxt = st_idle;
            endcase
        end
    end

    a_line_strobes : assert property (@(posedge CLK_IN) disable iff (RST_IN)
        !(ctl.scl_set && ctl.scl_clr) && !(ctl.sda_set && ctl.sda_clr))
        else $error("set and clear on one line");

endmodule

// ==== logic/i2c_shift_path.sv ====
// I2C shift path
// Byte shift register, bit counter, SCL/SDA drive-low registers and
// one sampling flop per incoming line
`timescale 1ns/10ps

module i2c_shift_path
(
    input  logic                       CLK_IN,
    input  logic                       RST_IN,
    input  logic                       run,
    input  i2c_pkg::line_ctl_t         ctl,
    input  logic [i2c_pkg::BYTE_W-1:0] wr_byte,
    input  logic                       scl,
    input  logic                       sda,
    output i2c_pkg::path_sta_t         fb,
    output logic [i2c_pkg::BYTE_W-1:0] rd_byte,
    output logic                       scl_low,
    output logic                       sda_low
);
    import i2c_pkg::*;

    logic [BYTE_W-1:0]    shft;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic                 scl_q;
    logic                 sda_q;

    // Line samplers
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            scl_q <= 1'b1;
            sda_q <= 1'b1;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
        end
    end

    // Drive-low registers, lines released while stopped
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN || !run)
        begin
            scl_low <= 1'b0;
            sda_low <= 1'b0;
        end
        else
        begin
            if (ctl.scl_clr)
                scl_low <= 1'b1;
            else if (ctl.scl_set)
                scl_low <= 1'b0;
            if (ctl.sda_clr)
                sda_low <= 1'b1;
            else if (ctl.sda_set)
                sda_low <= 1'b0;
        end
    end

    // MSB goes out first, sampled SDA comes in at the bottom
    always_ff @(posedge CLK_IN)
    begin
        if (ctl.shft_ld)
            shft <= wr_byte;
        else if (ctl.shft_nxt)
            shft <= {shft[BYTE_W-2:0], sda_q};
    end

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            bit_cnt <= '0;
        else if (ctl.bit_ld)
            bit_cnt <= BIT_CNT_W'(BYTE_W);
        else if (ctl.bit_dec)
            bit_cnt <= bit_cnt - 1'b1;
    end

    assign fb.scl_in   = scl_q;
    assign fb.sda_in   = sda_q;
    assign fb.shft_msb = shft[BYTE_W-1];
    assign fb.bit_end  = (bit_cnt == '0);
    assign rd_byte     = shft;

endmodule

// ==== logic/i2c_master_top.sv ====
// I2C master top level
// Connects the local-bus register file, the beat timer, the bus
// sequencer and the shift path; line drivers stay outside as drive-low outputs
`timescale 1ns/10ps

module i2c_master_top
#(
    parameter int BEAT_W = 16
)
(
    input  logic             CLK_IN,
    input  logic             RST_IN,
    input  i2c_pkg::lb_req_t lb_req,
    output i2c_pkg::lb_rsp_t lb_rsp,
    input  logic             scl,
    input  logic             sda,
    output logic             scl_low,
    output logic             sda_low
);
    import i2c_pkg::*;

    i2c_cmd_t          cmd;
    i2c_evt_t          evt;
    line_ctl_t         ctl;
    path_sta_t         fb;
    logic [BEAT_W-1:0] beat_len;
    logic              beat;
    logic [BYTE_W-1:0] wr_byte;
    logic [BYTE_W-1:0] rd_byte;

    i2c_lb_regs
    #(
        .BEAT_W (BEAT_W)
    )
    u_regs
    (
        .CLK_IN  (CLK_IN),
        .RST_IN  (RST_IN),
        .lb_req  (lb_req),
        .evt     (evt),
        .rd_byte (rd_byte),
        .lb_rsp  (lb_rsp),
        .cmd     (cmd),
        .beat    (beat_len),
        .wr_byte (wr_byte)
    );

    i2c_beat_timer
    #(
        .BEAT_W (BEAT_W)
    )
    u_timer
    (
        .CLK_IN   (CLK_IN),
        .RST_IN   (RST_IN),
        .run      (cmd.run),
        .beat_len (beat_len),
        .beat     (beat)
    );

    i2c_bit_fsm u_fsm
    (
        .CLK_IN (CLK_IN),
        .RST_IN (RST_IN),
        .cmd    (cmd),
        .beat   (beat),
        .fb     (fb),
        .ctl    (ctl),
        .evt    (evt)
    );

    i2c_shift_path u_path
    (
        .CLK_IN  (CLK_IN),
        .RST_IN  (RST_IN),
        .run     (cmd.run),
        .ctl     (ctl),
        .wr_byte (wr_byte),
        .scl     (scl),
        .sda     (sda),
        .fb      (fb),
        .rd_byte (rd_byte),
        .scl_low (scl_low),
        .sda_low (sda_low)
    );

endmodule

// ==== bench/i2c_slave_model.sv ====
// I2C slave model for the testbench
// Oversamples the bus lines, counts start, repeated start and stop conditions,
// captures written bytes, ACKs on request and drives read data in read mode
`timescale 1ns/10ps

module i2c_slave_model
(
    input  logic       CLK_IN,
    input  logic       RST_IN,
    input  logic       scl,
    input  logic       sda,
    input  logic       rd_mode,
    input  logic       ack_en,
    input  logic [7:0] rd_data,
    output logic       sda_rel,
    output logic [7:0] wr_byte,
    output logic [7:0] wr_cnt,
    output logic       mst_ack,
    output logic [7:0] start_cnt,
    output logic [7:0] rstart_cnt,
    output logic [7:0] stop_cnt
);

    logic       scl_q;
    logic       sda_q;
    logic       scl_p;
    logic       sda_p;
    logic       active;
    logic       seen_hi;
    logic [3:0] pos;
    logic [7:0] shreg;
    logic       drv_low;

    // The master holds every level for several clocks, so two samples see each edge
    always @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            scl_q <= 1'b1;
            sda_q <= 1'b1;
            scl_p <= 1'b1;
            sda_p <= 1'b1;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            scl_p <= scl_q;
            sda_p <= sda_q;
        end
    end

    always @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            active     <= 1'b0;
            seen_hi    <= 1'b0;
            pos        <= 4'd0;
            shreg      <= 8'd0;
            wr_byte    <= 8'd0;
            wr_cnt     <= 8'd0;
            mst_ack    <= 1'b0;
            start_cnt  <= 8'd0;
            rstart_cnt <= 8'd0;
            stop_cnt   <= 8'd0;
        end
        else if (scl_q && sda_p && !sda_q)
        begin
            // Start, or repeated start while the bus is still held
            if (active)
                rstart_cnt <= rstart_cnt + 8'd1;
            else
                start_cnt <= start_cnt + 8'd1;
            active  <= 1'b1;
            seen_hi <= 1'b0;
            pos     <= 4'd0;
        end
        else if (scl_q && !sda_p && sda_q)
        begin
            stop_cnt <= stop_cnt + 8'd1;
            active   <= 1'b0;
        end
        else if (active && !scl_p && scl_q)
        begin
            seen_hi <= 1'b1;
            if (pos < 4'd8)
                shreg <= {shreg[6:0], sda_q};
            else if (rd_mode)
                mst_ack <= !sda_q;
            else
            begin
                wr_byte <= shreg;
                wr_cnt  <= wr_cnt + 8'd1;
            end
        end
        else if (active && scl_p && !scl_q && seen_hi)
        begin
            // Ninth pulse closes the byte
            seen_hi <= 1'b0;
            pos     <= (pos == 4'd8) ? 4'd0 : pos + 4'd1;
        end
    end

    // Data bits in read mode, ACK slot in write mode
    assign drv_low = active && (rd_mode ? (pos < 4'd8 && !rd_data[3'd7 - pos[2:0]])
                                        : (pos == 4'd8 && ack_en));
    assign sda_rel = !drv_low;

endmodule

// ==== bench/tb_i2c_master.sv ====
// I2C master testbench
// Random transactions of start, writes, reads, repeated start and stop
// against a bus slave model, checked with a small expected-value model
`timescale 1ns/10ps

module tb_i2c_master;
    import i2c_pkg::*;

    localparam int BEAT_W   = 16;
    localparam int NUM_TXN  = 4;
    localparam int MAX_WR   = 3;
    localparam int BEAT_MAX = 9;
    // Start, writes, read and stop per transaction, plus two setup writes
    localparam int     CMD_CNT = NUM_TXN * (MAX_WR + 3) + 2;
    localparam longint WDOG_NS = longint'(CMD_CNT) * 40 * (BEAT_MAX + 1) * 8;

    logic              CLK_IN;
    logic              RST_IN;
    lb_req_t           lb_req;
    lb_rsp_t           lb_rsp;
    logic              scl_low;
    logic              sda_low;
    logic              scl;
    logic              sda;
    logic              sda_rel;
    logic              rd_mode;
    logic              ack_en;
    logic [7:0]        rd_data;
    logic [7:0]        wr_byte_seen;
    logic [7:0]        wr_cnt;
    logic              mst_ack;
    logic [7:0]        start_cnt;
    logic [7:0]        rstart_cnt;
    logic [7:0]        stop_cnt;
    logic [31:0]       rng;

    // Expected state
    logic              exp_bus;
    logic [7:0]        exp_starts;
    logic [7:0]        exp_rstarts;
    logic [7:0]        exp_stops;
    logic [7:0]        exp_wr_cnt;

    // Open-drain lines where the slave only ever pulls SDA
    assign scl = !scl_low;
    assign sda = !sda_low && sda_rel;

    i2c_master_top
    #(
        .BEAT_W (BEAT_W)
    )
    uut
    (
        .CLK_IN  (CLK_IN),
        .RST_IN  (RST_IN),
        .lb_req  (lb_req),
        .lb_rsp  (lb_rsp),
        .scl     (scl),
        .sda     (sda),
        .scl_low (scl_low),
        .sda_low (sda_low)
    );

    i2c_slave_model u_slave
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .scl        (scl),
        .sda        (sda),
        .rd_mode    (rd_mode),
        .ack_en     (ack_en),
        .rd_data    (rd_data),
        .sda_rel    (sda_rel),
        .wr_byte    (wr_byte_seen),
        .wr_cnt     (wr_cnt),
        .mst_ack    (mst_ack),
        .start_cnt  (start_cnt),
        .rstart_cnt (rstart_cnt),
        .stop_cnt   (stop_cnt)
    );

    always #4 CLK_IN = ~CLK_IN;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("mismatch at %0t ns: %s", $time, msg));
    endtask

    task automatic write_reg(input logic [LB_ADR_W-1:0] adr, input logic [LB_DAT_W-1:0] data);
        @(posedge CLK_IN);
        lb_req.adr <= adr;
        lb_req.din <= data;
        lb_req.wr  <= 1'b1;
        @(posedge CLK_IN);
        lb_req.wr  <= 1'b0;
    endtask

    task automatic read_reg(input logic [LB_ADR_W-1:0] adr, output logic [LB_DAT_W-1:0] data);
        @(posedge CLK_IN);
        lb_req.adr <= adr;
        lb_req.rd  <= 1'b1;
        @(posedge CLK_IN);
        lb_req.rd  <= 1'b0;
        @(negedge CLK_IN);
        assert (lb_rsp.vld)
            else abort_run("read data was not valid one cycle after the read strobe");
        data = lb_rsp.dout;
    endtask

    task automatic wait_ready(output logic [LB_DAT_W-1:0] sta);
        sta = '0;
        while (!sta[STA_RDY])
            read_reg(ADR_STA, sta);
    endtask

    task automatic run_command(input int cmd_bit, input logic ack, input logic exp_ack);
        logic [LB_DAT_W-1:0] sta;
        logic [LB_DAT_W-1:0] word;
        logic [LB_DAT_W-1:0] want;
        write_reg(ADR_STA, LB_DAT_W'(1) << STA_RDY);
        read_reg(ADR_STA, sta);
        assert (sta[STA_RDY] == 1'b0)
            else report_mismatch("ready still set after writing 1 to it");
        word            = '0;
        word[CTL_RUN]   = 1'b1;
        word[cmd_bit]   = 1'b1;
        word[CTL_ACK]   = ack;
        write_reg(ADR_CTL, word);
        wait_ready(sta);
        want          = '0;
        want[STA_RDY] = 1'b1;
        want[STA_ACK] = exp_ack;
        want[STA_BUS] = exp_bus;
        assert (sta == want)
            else report_mismatch($sformatf("status %h, expected %h", sta, want));
        // Command bits gone while run and ack stay
        read_reg(ADR_CTL, sta);
        want          = '0;
        want[CTL_RUN] = 1'b1;
        want[CTL_ACK] = ack;
        assert (sta == want)
            else report_mismatch($sformatf("control %h, expected %h", sta, want));
    endtask

    task automatic check_conditions();
        assert (start_cnt == exp_starts && rstart_cnt == exp_rstarts && stop_cnt == exp_stops)
            else report_mismatch($sformatf("start/rstart/stop %0d/%0d/%0d, expected %0d/%0d/%0d",
                                           start_cnt, rstart_cnt, stop_cnt,
                                           exp_starts, exp_rstarts, exp_stops));
    endtask

    task automatic send_start();
        if (exp_bus)
            exp_rstarts = exp_rstarts + 8'd1;
        else
            exp_starts = exp_starts + 8'd1;
        exp_bus = 1'b1;
        run_command(CTL_STR, 1'b0, 1'b0);
        check_conditions();
    endtask

    task automatic send_stop();
        exp_stops = exp_stops + 8'd1;
        exp_bus   = 1'b0;
        run_command(CTL_STP, 1'b0, 1'b0);
        check_conditions();
    endtask

    task automatic write_byte();
        logic [7:0] data;
        logic       slv_ack;
        rng     = xorshift(rng);
        data    = rng[7:0];
        rng     = xorshift(rng);
        slv_ack = rng[0];
        write_reg(ADR_WR_DAT, LB_DAT_W'(data));
        ack_en     <= slv_ack;
        exp_wr_cnt  = exp_wr_cnt + 8'd1;
        run_command(CTL_WR, 1'b0, slv_ack);
        assert (wr_cnt == exp_wr_cnt && wr_byte_seen == data)
            else report_mismatch($sformatf("slave byte %h count %0d, expected %h count %0d",
                                           wr_byte_seen, wr_cnt, data, exp_wr_cnt));
    endtask

    task automatic read_byte();
        logic [7:0]          data;
        logic                m_ack;
        logic [LB_DAT_W-1:0] got;
        rng   = xorshift(rng);
        data  = rng[7:0];
        rng   = xorshift(rng);
        m_ack = rng[0];
        @(posedge CLK_IN);
        rd_data <= data;
        rd_mode <= 1'b1;
        run_command(CTL_RD, m_ack, 1'b0);
        read_reg(ADR_RD_DAT, got);
        assert (got == LB_DAT_W'(data))
            else report_mismatch($sformatf("read data %h, expected %h", got, data));
        assert (mst_ack == m_ack)
            else report_mismatch($sformatf("master ack %b, expected %b", mst_ack, m_ack));
        @(posedge CLK_IN);
        rd_mode <= 1'b0;
    endtask

    initial
    begin
        #(WDOG_NS);
        abort_run("timeout, the DUT did not finish its commands in time");
    end

    initial
    begin
        logic [LB_DAT_W-1:0] rdat;
        logic [BEAT_W-1:0]   beat_val;
        int                  n_wr;
        CLK_IN      = 1'b0;
        RST_IN     <= 1'b1;
        lb_req     <= '0;
        rd_mode    <= 1'b0;
        ack_en     <= 1'b0;
        rd_data    <= 8'd0;
        rng         = 32'hf704_9e27;
        exp_bus     = 1'b0;
        exp_starts  = 8'd0;
        exp_rstarts = 8'd0;
        exp_stops   = 8'd0;
        exp_wr_cnt  = 8'd0;
        repeat (5) @(posedge CLK_IN);
        RST_IN <= 1'b0;
        @(negedge CLK_IN);
        assert (scl_low == 1'b0 && sda_low == 1'b0)
            else report_mismatch("lines not released after reset");
        read_reg(ADR_STA, rdat);
        assert (rdat == '0)
            else report_mismatch($sformatf("status %h after reset, expected 0", rdat));

        // Beat from 2 to 9
        rng      = xorshift(rng);
        beat_val = BEAT_W'(2) + BEAT_W'(rng[2:0]);
        write_reg(ADR_BEAT, LB_DAT_W'(beat_val));
        read_reg(ADR_BEAT, rdat);
        assert (rdat == LB_DAT_W'(beat_val))
            else report_mismatch($sformatf("beat %h, expected %h", rdat, beat_val));
        write_reg(ADR_CTL, LB_DAT_W'(1) << CTL_RUN);

        for (int t = 0; t < NUM_TXN; t++)
        begin
            send_start();
            rng  = xorshift(rng);
            n_wr = int'(rng % MAX_WR) + 1;
            repeat (n_wr) write_byte();
            // The first transaction always reads
            rng = xorshift(rng);
            if (rng[0] || t == 0)
                read_byte();
            // Even transactions keep the bus for a repeated start
            if (t % 2 == 1)
                send_stop();
        end

        @(negedge CLK_IN);
        assert (scl == 1'b1 && sda == 1'b1)
            else report_mismatch("bus lines not high after the final stop");
        $display("Test OK");
        $finish;
    end

endmodule

// ==== src.f ====
logic/i2c_pkg.sv
logic/i2c_beat_timer.sv
logic/i2c_lb_regs.sv
logic/i2c_bit_fsm.sv
logic/i2c_shift_path.sv
logic/i2c_master_top.sv
bench/i2c_slave_model.sv
bench/tb_i2c_master.sv

// ==== Makefile ====
# Verilator build and run for the I2C master testbench
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_i2c_master
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = Test OK

SRCS = $(wildcard logic/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# Pass only if the log holds the pass line
run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^$(PASS)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
